// ==== imuldiv.f ====
+incdir+tb
src/imuldiv_pkg.sv
src/imuldiv_mul_dpath.sv
src/imuldiv_mul_ctrl.sv
src/imuldiv_div_dpath.sv
src/imuldiv_div_ctrl.sv
src/imuldiv_order_queue.sv
src/imuldiv_top.sv
tb/imuldiv_tb.sv

// ==== src/imuldiv_div_ctrl.sv ====
// --------------------------------------------------------------------------
// divide control
// idle/calc/done FSM with its own down-counter over the quotient bits
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_div_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  imuldiv_pkg::ctrl_state_e state;
  imuldiv_pkg::ctrl_state_e state_next;
  // bits still to produce, minus one
  imuldiv_pkg::count_t      count;
  imuldiv_pkg::count_t      count_next;

  // ------------------------------------------------------------------------
  // next state
  // ------------------------------------------------------------------------
  always_comb begin
    state_next = state;
    count_next = count;
    case (state)
      imuldiv_pkg::st_idle: begin
        if (req_val) begin
          state_next = imuldiv_pkg::st_calc;
          count_next = imuldiv_pkg::count_t'(imuldiv_pkg::iter_last);
        end
      end
      imuldiv_pkg::st_calc: begin
        // last quotient bit at count zero
        if (count == '0) begin
          state_next = imuldiv_pkg::st_done;
        end else begin
          count_next = count - 1'b1;
        end
      end
      imuldiv_pkg::st_done: begin
        if (resp_rdy) begin
          state_next = imuldiv_pkg::st_idle;
        end
      end
      default: state_next = imuldiv_pkg::st_idle;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      count <= '0;
    end else begin
      state <= state_next;
      count <= count_next;
    end
  end

  // handshake and datapath strobes
  assign req_rdy  = (state == imuldiv_pkg::st_idle);
  assign resp_val = (state == imuldiv_pkg::st_done);
  assign step     = (state == imuldiv_pkg::st_calc);
  assign load     = req_rdy & req_val;

endmodule

// ==== src/imuldiv_div_dpath.sv ====
// --------------------------------------------------------------------------
// divide datapath
// restoring shift-and-subtract, signed or unsigned, signs fixed at the end
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_div_dpath (
  input  logic                      clk,
  input  logic                      reset,
  input  logic                      load,
  input  logic                      step,
  input  imuldiv_pkg::imuldiv_req_t req,
  output imuldiv_pkg::dword_t       result
);

  // signed operation requested
  logic               signed_op;
  // operands as divided, magnitudes for fn_div
  imuldiv_pkg::word_t a_mag;
  imuldiv_pkg::word_t b_mag;

  // partial remainder, and dividend bits shifting out as quotient bits shift in
  imuldiv_pkg::word_t rem;
  imuldiv_pkg::word_t quot;
  imuldiv_pkg::word_t dvsr;

  // saved at load
  logic sign_a;
  logic sign_b;
  logic is_signed;

  // one iteration
  logic [imuldiv_pkg::nbits:0]   rem_sh;
  logic [imuldiv_pkg::nbits+1:0] diff;
  logic                          fits;

  // results with the sign rules applied
  imuldiv_pkg::word_t quot_fix;
  imuldiv_pkg::word_t rem_fix;

  assign signed_op = (req.fn == imuldiv_pkg::fn_div);

  assign a_mag = (signed_op && req.a[imuldiv_pkg::nbits-1]) ? (~req.a + 1'b1) : req.a;
  assign b_mag = (signed_op && req.b[imuldiv_pkg::nbits-1]) ? (~req.b + 1'b1) : req.b;

  // ------------------------------------------------------------------------
  // trial subtract
  // ------------------------------------------------------------------------

  // next dividend bit moves into the remainder
  assign rem_sh = {rem, quot[imuldiv_pkg::nbits-1]};
  // extra top bit catches the borrow even when rem_sh is 33 bits wide
  assign diff   = {1'b0, rem_sh} - {2'b00, dvsr};
  assign fits   = ~diff[imuldiv_pkg::nbits+1];

  // sign flags
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a    <= 1'b0;
      sign_b    <= 1'b0;
      is_signed <= 1'b0;
    end else if (load) begin
      sign_a    <= req.a[imuldiv_pkg::nbits-1];
      sign_b    <= req.b[imuldiv_pkg::nbits-1];
      is_signed <= signed_op;
    end
  end

  // remainder, quotient and divisor
  always_ff @(posedge clk) begin
    if (load) begin
      rem  <= '0;
      quot <= a_mag;
      dvsr <= b_mag;
    end else if (step) begin
      if (fits) begin
        // difference kept, quotient bit is one
        rem  <= diff[imuldiv_pkg::nbits-1:0];
        quot <= {quot[imuldiv_pkg::nbits-2:0], 1'b1};
      end else begin
        // restore, quotient bit is zero
        rem  <= rem_sh[imuldiv_pkg::nbits-1:0];
        quot <= {quot[imuldiv_pkg::nbits-2:0], 1'b0};
      end
    end
  end

  // ------------------------------------------------------------------------
  // sign fix
  // ------------------------------------------------------------------------

  // quotient negative when signs differ, remainder follows the dividend
  assign quot_fix = (is_signed && (sign_a ^ sign_b)) ? (~quot + 1'b1) : quot;
  assign rem_fix  = (is_signed && sign_a) ? (~rem + 1'b1) : rem;

  assign result = {rem_fix, quot_fix};

endmodule

// ==== src/imuldiv_mul_ctrl.sv ====
// --------------------------------------------------------------------------
// multiply control
// idle/calc/done FSM, one calc cycle per multiplier bit
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_mul_ctrl (
  input  logic clk,
  input  logic reset,
  input  logic req_val,
  output logic req_rdy,
  output logic resp_val,
  input  logic resp_rdy,
  output logic load,
  output logic step
);

  imuldiv_pkg::ctrl_state_e state;
  imuldiv_pkg::count_t      count;

  // handshake transfers
  logic req_go;
  logic resp_go;

  assign req_go  = req_val & req_rdy;
  assign resp_go = resp_val & resp_rdy;

  // ------------------------------------------------------------------------
  // state and iteration counter
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      state <= imuldiv_pkg::st_idle;
      count <= '0;
    end else begin
      case (state)
        imuldiv_pkg::st_idle: begin
          // counter restarts with every accepted request
          if (req_go) begin
            state <= imuldiv_pkg::st_calc;
            count <= '0;
          end
        end
        imuldiv_pkg::st_calc: begin
          if (count == imuldiv_pkg::count_t'(imuldiv_pkg::iter_last)) begin
            state <= imuldiv_pkg::st_done;
          end else begin
            count <= count + 1'b1;
          end
        end
        imuldiv_pkg::st_done: begin
          // hold the product until the consumer takes it
          if (resp_go) begin
            state <= imuldiv_pkg::st_idle;
          end
        end
        default: state <= imuldiv_pkg::st_idle;
      endcase
    end
  end

  // outputs are pure state decodes
  always_comb begin
    req_rdy  = (state == imuldiv_pkg::st_idle);
    step     = (state == imuldiv_pkg::st_calc);
    resp_val = (state == imuldiv_pkg::st_done);
  end

  // capture operands on the accept edge
  assign load = req_go;

endmodule

// ==== src/imuldiv_mul_dpath.sv ====
// --------------------------------------------------------------------------
// multiply datapath
// shift-and-add on operand magnitudes, sign applied to the final product
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_mul_dpath (
  input  logic                clk,
  input  logic                reset,
  input  logic                load,
  input  logic                step,
  input  imuldiv_pkg::word_t  a,
  input  imuldiv_pkg::word_t  b,
  output imuldiv_pkg::dword_t result
);

  // magnitudes of the incoming operands
  imuldiv_pkg::word_t  a_mag;
  imuldiv_pkg::word_t  b_mag;

  // multiplicand moves left, multiplier moves right
  imuldiv_pkg::dword_t a_reg;
  imuldiv_pkg::word_t  b_reg;

  // running sum of partial products
  imuldiv_pkg::dword_t acc;

  // operand signs saved at load time
  logic sign_a;
  logic sign_b;

  // two's complement when the sign bit is set
  assign a_mag = a[imuldiv_pkg::nbits-1] ? (~a + 1'b1) : a;
  assign b_mag = b[imuldiv_pkg::nbits-1] ? (~b + 1'b1) : b;

  // ------------------------------------------------------------------------
  // accumulator and saved signs
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (reset) begin
      sign_a <= 1'b0;
      sign_b <= 1'b0;
      acc    <= '0;
    end else if (load) begin
      sign_a <= a[imuldiv_pkg::nbits-1];
      sign_b <= b[imuldiv_pkg::nbits-1];
      acc    <= '0;
    end else if (step && b_reg[0]) begin
      // current multiplier bit set, add the shifted multiplicand
      acc <= acc + a_reg;
    end
  end

  // ------------------------------------------------------------------------
  // operand shift registers
  // ------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      // zero-extend so the multiplicand can move into the upper half
      a_reg <= imuldiv_pkg::dword_t'(a_mag);
      b_reg <= b_mag;
    end else if (step) begin
      a_reg <= a_reg << 1;
      b_reg <= b_reg >> 1;
    end
  end

  // negative product when exactly one operand was negative
  assign result = (sign_a ^ sign_b) ? (~acc + 1'b1) : acc;

endmodule

// ==== src/imuldiv_order_queue.sv ====
// --------------------------------------------------------------------------
// order queue
// two-entry FIFO of unit tags, head names the unit whose response is next
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_order_queue (
  input  logic               clk,
  input  logic               reset,
  input  logic               push,
  input  imuldiv_pkg::unit_t push_tag,
  input  logic               pop,
  output imuldiv_pkg::unit_t head_tag,
  output logic               head_val,
  output logic               full
);

  // tag storage
  imuldiv_pkg::unit_t tags [2];

  logic       rd_ptr;
  logic       wr_ptr;
  // occupancy, 0 to 2
  logic [1:0] count;

  always_ff @(posedge clk) begin
    if (reset) begin
      rd_ptr <= 1'b0;
      wr_ptr <= 1'b0;
      count  <= 2'd0;
    end else begin
      if (push) begin
        wr_ptr <= ~wr_ptr;
      end
      if (pop) begin
        rd_ptr <= ~rd_ptr;
      end
      // push and pop together leave the count unchanged
      case ({push, pop})
        2'b10:   count <= count + 2'd1;
        2'b01:   count <= count - 2'd1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      tags[wr_ptr] <= push_tag;
    end
  end

  // head visible in the same cycle, no added latency
  assign head_tag = tags[rd_ptr];
  assign head_val = (count != 2'd0);
  assign full     = (count == 2'd2);

endmodule

// ==== src/imuldiv_pkg.sv ====
// --------------------------------------------------------------------------
// iterative multiply/divide unit shared definitions
// widths, operation codes, control states and the request record
// --------------------------------------------------------------------------
package imuldiv_pkg;

  // operand width
  localparam int nbits = 32;
  // count value seen in the last calc cycle
  localparam int iter_last = nbits - 1;

  // ------------------------------------------------------------------------
  // data widths
  // ------------------------------------------------------------------------

  // one operand, or one half of a result
  typedef logic [nbits-1:0] word_t;
  // full product, or remainder:quotient pair
  typedef logic [2*nbits-1:0] dword_t;
  // iteration index, one value per result bit
  typedef logic [$clog2(nbits)-1:0] count_t;

  // tag kept in the order queue, names the unit that owes a response
  typedef logic unit_t;
  localparam unit_t unit_mul = 1'b0;
  localparam unit_t unit_div = 1'b1;

  // ------------------------------------------------------------------------
  // encodings
  // ------------------------------------------------------------------------

  typedef enum logic [1:0] {
    fn_mul  = 2'd0,
    fn_div  = 2'd1,
    fn_divu = 2'd2
  } imuldiv_fn_e;

  // shared by the multiply and divide control FSMs
  typedef enum logic [1:0] {
    st_idle = 2'd0,
    st_calc = 2'd1,
    st_done = 2'd2
  } ctrl_state_e;

  // request record, operation code then the two operands
  typedef struct packed {
    imuldiv_fn_e fn;
    word_t       a;
    word_t       b;
  } imuldiv_req_t;

endpackage

// ==== src/imuldiv_top.sv ====
// --------------------------------------------------------------------------
// iterative multiply/divide unit
// routes requests by operation, returns responses in request order
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_top (
  input  logic                      clk,
  input  logic                      reset,
  input  imuldiv_pkg::imuldiv_req_t req,
  input  logic                      req_val,
  output logic                      req_rdy,
  output imuldiv_pkg::dword_t       resp_result,
  output logic                      resp_val,
  input  logic                      resp_rdy
);

  // request side
  logic               is_div;
  logic               mul_req_val;
  logic               mul_req_rdy;
  logic               div_req_val;
  logic               div_req_rdy;

  // response side
  logic               mul_resp_val;
  logic               mul_resp_rdy;
  logic               div_resp_val;
  logic               div_resp_rdy;
  imuldiv_pkg::dword_t mul_result;
  imuldiv_pkg::dword_t div_result;

  // control to datapath
  logic               mul_load;
  logic               mul_step;
  logic               div_load;
  logic               div_step;

  // order queue
  logic               q_push;
  logic               q_pop;
  logic               q_full;
  logic               q_head_val;
  imuldiv_pkg::unit_t q_head_tag;
  logic               head_is_div;

  // ------------------------------------------------------------------------
  // request routing
  // ------------------------------------------------------------------------

  // fn_div and fn_divu both go to the divider
  assign is_div      = (req.fn != imuldiv_pkg::fn_mul);
  // a full queue blocks every request
  assign mul_req_val = req_val & ~is_div & ~q_full;
  assign div_req_val = req_val & is_div & ~q_full;
  assign req_rdy     = (is_div ? div_req_rdy : mul_req_rdy) & ~q_full;
  assign q_push      = req_val & req_rdy;

  // ------------------------------------------------------------------------
  // response steering
  // ------------------------------------------------------------------------

  // only the unit at the queue head sees resp_rdy
  assign head_is_div  = (q_head_tag == imuldiv_pkg::unit_div);
  assign mul_resp_rdy = resp_rdy & q_head_val & ~head_is_div;
  assign div_resp_rdy = resp_rdy & q_head_val & head_is_div;
  assign resp_val     = q_head_val & (head_is_div ? div_resp_val : mul_resp_val);
  assign resp_result  = head_is_div ? div_result : mul_result;
  assign q_pop        = resp_val & resp_rdy;

  imuldiv_mul_ctrl u_mul_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (mul_req_val),
    .req_rdy  (mul_req_rdy),
    .resp_val (mul_resp_val),
    .resp_rdy (mul_resp_rdy),
    .load     (mul_load),
    .step     (mul_step)
  );

  imuldiv_mul_dpath u_mul_dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (mul_load),
    .step   (mul_step),
    .a      (req.a),
    .b      (req.b),
    .result (mul_result)
  );

  imuldiv_div_ctrl u_div_ctrl (
    .clk      (clk),
    .reset    (reset),
    .req_val  (div_req_val),
    .req_rdy  (div_req_rdy),
    .resp_val (div_resp_val),
    .resp_rdy (div_resp_rdy),
    .load     (div_load),
    .step     (div_step)
  );

  imuldiv_div_dpath u_div_dpath (
    .clk    (clk),
    .reset  (reset),
    .load   (div_load),
    .step   (div_step),
    .req    (req),
    .result (div_result)
  );

  // tag follows the unit that accepted the request
  imuldiv_order_queue u_order_queue (
    .clk      (clk),
    .reset    (reset),
    .push     (q_push),
    .push_tag (is_div ? imuldiv_pkg::unit_div : imuldiv_pkg::unit_mul),
    .pop      (q_pop),
    .head_tag (q_head_tag),
    .head_val (q_head_val),
    .full     (q_full)
  );

endmodule

// ==== tb/imuldiv_tb_util.svh ====
// --------------------------------------------------------------------------
// testbench helpers for the multiply/divide unit
// random source, reference models and typed compare tasks
// --------------------------------------------------------------------------
`ifndef IMULDIV_TB_UTIL_SVH
`define IMULDIV_TB_UTIL_SVH

// galois lfsr state over x^32 + x^22 + x^2 + x + 1
logic [31:0] lfsr_state = 32'h4442;

// one lfsr step per bit taken
function automatic logic next_bit();
  logic out;
  out = lfsr_state[0];
  lfsr_state = lfsr_state >> 1;
  if (out) begin
    lfsr_state = lfsr_state ^ 32'h8020_0003;
  end
  return out;
endfunction

// n random bits packed into the low end of a word
function automatic imuldiv_pkg::word_t rand_bits(input int n);
  imuldiv_pkg::word_t v;
  int                 i;
  v = '0;
  for (i = 0; i < n; i++) begin
    v = {v[imuldiv_pkg::nbits-2:0], next_bit()};
  end
  return v;
endfunction

// --------------------------------------------------------------------------
// reference models
// --------------------------------------------------------------------------

// full two's complement product of the sign-extended operands
function automatic imuldiv_pkg::dword_t mul_model(input imuldiv_pkg::word_t a,
                                                  input imuldiv_pkg::word_t b);
  logic signed [2*imuldiv_pkg::nbits-1:0] a_ext;
  logic signed [2*imuldiv_pkg::nbits-1:0] b_ext;
  a_ext = {{imuldiv_pkg::nbits{a[imuldiv_pkg::nbits-1]}}, a};
  b_ext = {{imuldiv_pkg::nbits{b[imuldiv_pkg::nbits-1]}}, b};
  return a_ext * b_ext;
endfunction

// remainder in the upper half and quotient in the lower half
function automatic imuldiv_pkg::dword_t div_model(input logic signed_op,
                                                  input imuldiv_pkg::word_t a,
                                                  input imuldiv_pkg::word_t b);
  imuldiv_pkg::word_t a_mag;
  imuldiv_pkg::word_t b_mag;
  imuldiv_pkg::word_t q;
  imuldiv_pkg::word_t r;
  logic               sa;
  logic               sb;
  sa    = signed_op & a[imuldiv_pkg::nbits-1];
  sb    = signed_op & b[imuldiv_pkg::nbits-1];
  a_mag = sa ? (~a + 32'd1) : a;
  b_mag = sb ? (~b + 32'd1) : b;
  if (b_mag == '0) begin
    // divide by zero gives an all-ones quotient magnitude and the dividend as remainder
    q = '1;
    r = a_mag;
  end else begin
    q = a_mag / b_mag;
    r = a_mag % b_mag;
  end
  if (sa ^ sb) begin
    q = ~q + 32'd1;
  end
  // remainder takes the dividend's sign
  if (sa) begin
    r = ~r + 32'd1;
  end
  return {r, q};
endfunction

function automatic imuldiv_pkg::dword_t ref_model(input imuldiv_pkg::imuldiv_req_t r);
  if (r.fn == imuldiv_pkg::fn_mul) begin
    return mul_model(r.a, r.b);
  end
  return div_model(r.fn == imuldiv_pkg::fn_div, r.a, r.b);
endfunction

// --------------------------------------------------------------------------
// compare tasks
// --------------------------------------------------------------------------

task automatic check_dword(input string name, input imuldiv_pkg::dword_t got,
                           input imuldiv_pkg::dword_t exp);
  if (got !== exp) begin
    report_fail($sformatf("FAIL at %0t ns: %s = %h, expected %h", $time, name, got, exp));
  end
endtask

task automatic check_bit(input string name, input logic got, input logic exp);
  if (got !== exp) begin
    report_fail($sformatf("FAIL at %0t ns: %s = %b, expected %b", $time, name, got, exp));
  end
endtask

`endif

// ==== tb/imuldiv_tb.sv ====
// --------------------------------------------------------------------------
// testbench for the iterative multiply/divide unit
// directed multiply, divide, ordering and random stream tests
// --------------------------------------------------------------------------
`timescale 1ns/1ns

module imuldiv_tb;

  // edges from the accept edge to the edge that raises resp_val
  localparam int resp_edges = 32;
  // cycle limit for every wait loop
  localparam int wait_limit = 300;
  localparam int n_random   = 200;

  logic                      clk;
  logic                      reset;
  imuldiv_pkg::imuldiv_req_t req;
  logic                      req_val;
  logic                      req_rdy;
  imuldiv_pkg::dword_t       resp_result;
  logic                      resp_val;
  logic                      resp_rdy;

  // model results in request order
  imuldiv_pkg::dword_t expect_q [$];

  // prints what went wrong and stops the run
  task automatic report_fail(input string what);
    $display("%s", what);
    $display("ERRORS FOUND");
    $fatal(1);
  endtask

  `include "imuldiv_tb_util.svh"

  imuldiv_top u_imuldiv_top (
    .clk         (clk),
    .reset       (reset),
    .req         (req),
    .req_val     (req_val),
    .req_rdy     (req_rdy),
    .resp_result (resp_result),
    .resp_val    (resp_val),
    .resp_rdy    (resp_rdy)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  // --------------------------------------------------------------------------
  // handshake tasks
  // --------------------------------------------------------------------------

  // hold val until the negedge sees rdy and return on the accept edge
  task automatic wait_accept();
    int n;
    n = 0;
    @(negedge clk);
    while (!req_rdy) begin
      n++;
      if (n > wait_limit) begin
        report_fail("timeout: request was never accepted");
      end
      @(negedge clk);
    end
    @(posedge clk);
    req_val <= 1'b0;
  endtask

  task automatic send_req(input imuldiv_pkg::imuldiv_req_t r);
    @(posedge clk);
    req     <= r;
    req_val <= 1'b1;
    wait_accept();
  endtask

  // with stall set the lfsr keeps resp_rdy high about three cycles in four
  task automatic take_resp(input imuldiv_pkg::dword_t exp, input logic stall);
    int   n;
    logic done;
    n    = 0;
    done = 1'b0;
    while (!done) begin
      @(posedge clk);
      resp_rdy <= stall ? (|rand_bits(2)) : 1'b1;
      @(negedge clk);
      if (resp_val && resp_rdy) begin
        check_dword("resp_result", resp_result, exp);
        done = 1'b1;
      end
      n++;
      if (!done && n > wait_limit) begin
        report_fail("timeout: no response arrived");
      end
    end
    // transfer edge
    @(posedge clk);
    resp_rdy <= 1'b0;
  endtask

  // one operation with the fixed response latency checked
  task automatic run_op(input imuldiv_pkg::imuldiv_fn_e fn, input imuldiv_pkg::word_t a,
                        input imuldiv_pkg::word_t b);
    imuldiv_pkg::imuldiv_req_t r;
    int                        k;
    r.fn = fn;
    r.a  = a;
    r.b  = b;
    send_req(r);
    for (k = 0; k < resp_edges; k++) begin
      @(negedge clk);
      check_bit("resp_val", resp_val, 1'b0);
    end
    @(negedge clk);
    check_bit("resp_val", resp_val, 1'b1);
    take_resp(ref_model(r), 1'b0);
  endtask

  // --------------------------------------------------------------------------
  // tests
  // --------------------------------------------------------------------------

  task automatic after_reset();
    @(negedge clk);
    check_bit("resp_val", resp_val, 1'b0);
    check_bit("req_rdy", req_rdy, 1'b1);
  endtask

  task automatic mul_cases();
    run_op(imuldiv_pkg::fn_mul, 32'd0, 32'd12345);
    run_op(imuldiv_pkg::fn_mul, 32'd1, 32'h1234_5678);
    run_op(imuldiv_pkg::fn_mul, -32'd1, 32'd7);
    run_op(imuldiv_pkg::fn_mul, -32'd3, 32'd5);
    run_op(imuldiv_pkg::fn_mul, 32'd3, -32'd5);
    run_op(imuldiv_pkg::fn_mul, -32'd1, -32'd1);
    run_op(imuldiv_pkg::fn_mul, 32'h8000_0000, 32'd1);
    run_op(imuldiv_pkg::fn_mul, 32'h8000_0000, -32'd1);
    run_op(imuldiv_pkg::fn_mul, 32'h8000_0000, 32'h8000_0000);
    run_op(imuldiv_pkg::fn_mul, 32'h7fff_ffff, 32'h7fff_ffff);
  endtask

  task automatic div_cases();
    run_op(imuldiv_pkg::fn_div, 32'd100, 32'd7);
    run_op(imuldiv_pkg::fn_div, -32'd100, 32'd7);
    run_op(imuldiv_pkg::fn_div, 32'd100, -32'd7);
    run_op(imuldiv_pkg::fn_div, -32'd100, -32'd7);
    run_op(imuldiv_pkg::fn_div, 32'd5, 32'd0);
    run_op(imuldiv_pkg::fn_div, -32'd5, 32'd0);
    run_op(imuldiv_pkg::fn_div, 32'h8000_0000, -32'd1);
    run_op(imuldiv_pkg::fn_div, 32'd0, 32'd3);
    run_op(imuldiv_pkg::fn_divu, 32'd100, 32'd7);
    run_op(imuldiv_pkg::fn_divu, 32'hffff_ffff, 32'd2);
    run_op(imuldiv_pkg::fn_divu, 32'h8000_0000, 32'd0);
    run_op(imuldiv_pkg::fn_divu, 32'd3, 32'hffff_fff0);
  endtask

  // multiply then divide held back while a third request waits
  task automatic order_and_block();
    imuldiv_pkg::imuldiv_req_t r1;
    imuldiv_pkg::imuldiv_req_t r2;
    imuldiv_pkg::imuldiv_req_t r3;
    int                        n;
    r1.fn = imuldiv_pkg::fn_mul;
    r1.a  = -32'd1234;
    r1.b  = 32'd5678;
    r2.fn = imuldiv_pkg::fn_div;
    r2.a  = -32'd99999;
    r2.b  = 32'd37;
    r3.fn = imuldiv_pkg::fn_mul;
    r3.a  = 32'h0001_0003;
    r3.b  = 32'h0002_0005;
    send_req(r1);
    send_req(r2);
    @(posedge clk);
    req     <= r3;
    req_val <= 1'b1;
    n = 0;
    @(negedge clk);
    while (!resp_val) begin
      check_bit("req_rdy", req_rdy, 1'b0);
      n++;
      if (n > wait_limit) begin
        report_fail("timeout: first response never became valid");
      end
      @(negedge clk);
    end
    // head result must hold while resp_rdy stays low
    repeat (8) begin
      check_bit("req_rdy", req_rdy, 1'b0);
      check_bit("resp_val", resp_val, 1'b1);
      check_dword("resp_result", resp_result, ref_model(r1));
      @(negedge clk);
    end
    take_resp(ref_model(r1), 1'b0);
    // third request goes in once the multiplier is free
    wait_accept();
    take_resp(ref_model(r2), 1'b0);
    take_resp(ref_model(r3), 1'b0);
  endtask

  task automatic random_stream();
    imuldiv_pkg::imuldiv_req_t reqs [n_random];
    imuldiv_pkg::word_t        f;
    int                        i;
    int                        j;
    int                        n;
    // operations drawn before the stream starts
    for (i = 0; i < n_random; i++) begin
      f = rand_bits(2);
      reqs[i].fn = (f == 32'd3) ? imuldiv_pkg::fn_mul : imuldiv_pkg::imuldiv_fn_e'(f[1:0]);
      reqs[i].a  = rand_bits(32);
      reqs[i].b  = rand_bits(32);
      // small divisors now and then
      if (next_bit()) begin
        reqs[i].b = reqs[i].b >> rand_bits(5);
      end
    end
    fork
      begin
        for (i = 0; i < n_random; i++) begin
          expect_q.push_back(ref_model(reqs[i]));
          send_req(reqs[i]);
        end
      end
      begin
        for (j = 0; j < n_random; j++) begin
          n = 0;
          while (expect_q.size() == 0) begin
            n++;
            if (n > wait_limit) begin
              report_fail("timeout: no request issued for the next response");
            end
            @(negedge clk);
          end
          take_resp(expect_q.pop_front(), 1'b1);
        end
      end
    join
  endtask

  // --------------------------------------------------------------------------
  // main sequence
  // --------------------------------------------------------------------------
  initial begin
    reset    = 1'b1;
    req      = '0;
    req_val  = 1'b0;
    resp_rdy = 1'b0;
    repeat (2) @(posedge clk);
    reset <= 1'b0;
    after_reset();
    mul_cases();
    div_cases();
    order_and_block();
    random_stream();
    $display("NO ERRORS");
    $finish;
  end

endmodule
